// File: build.f
src/blur_pkg.sv
src/ctrl_pkg.sv
src/pixel_ram.sv
src/image_loader.sv
src/window_fetch.sv
src/gaussian_3x3.sv
src/result_streamer.sv
src/blur_controller.sv
src/blur_top.sv
verification/blur_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the blur testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module blur_tb -f build.f -o blur_sim; then
    echo "compile failed"
    exit 1
fi

sim_out=$(./obj_dir/blur_sim)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qF '** PASS **' <<< "$sim_out"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi

// File: src/blur_controller.sv
module blur_controller (
    input  logic                 clk_100mhz,
    input  logic                 sys_rst,
    input  logic                 full_i,
    input  logic                 last_i,
    output logic                 load_en_o,
    output logic                 issue_o,
    output blur_pkg::coord_t     row_o,
    output blur_pkg::coord_t     col_o,
    output ctrl_pkg::tap_t       tap_o,
    input  logic                 filt_valid_i,
    input  blur_pkg::pixel_t     filt_pix_i,
    output blur_pkg::write_req_t res_wr_o,
    output logic                 read_start_o,
    output ctrl_pkg::status_t    status_o,
    output logic                 frame_done_o
);

    ctrl_pkg::ctrl_state_e state;
    logic [2:0] drain_cnt;
    blur_pkg::pix_addr_t addr_pipe [4];  // centre address, lined up with the filter
    logic last_centre;
    logic drain_end;

    assign load_en_o = (state == ctrl_pkg::st_load);
    assign issue_o = (state == ctrl_pkg::st_blur);
    assign status_o.loading = (state == ctrl_pkg::st_load);
    assign status_o.blurring = (state == ctrl_pkg::st_blur) || (state == ctrl_pkg::st_drain);
    assign status_o.reading = (state == ctrl_pkg::st_read);

    assign last_centre = (tap_o == ctrl_pkg::tap_last) && (row_o == blur_pkg::coord_last)
                         && (col_o == blur_pkg::coord_last);
    assign drain_end = (drain_cnt == 3'(ctrl_pkg::drain_cycles - 1));

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            state <= ctrl_pkg::st_load;
            tap_o <= '0;
            row_o <= '0;
            col_o <= '0;
            drain_cnt <= '0;
            read_start_o <= 1'b0;
            frame_done_o <= 1'b0;
        end else begin
            read_start_o <= 1'b0;
            frame_done_o <= 1'b0;
            case (state)
                ctrl_pkg::st_load: if (full_i) state <= ctrl_pkg::st_blur;
                ctrl_pkg::st_blur: begin
                    // one tap per cycle, centres walk in raster order
                    if (tap_o == ctrl_pkg::tap_last) begin
                        tap_o <= '0;
                        col_o <= col_o + 4'd1;
                        if (col_o == blur_pkg::coord_last) row_o <= row_o + 4'd1;
                    end else begin
                        tap_o <= tap_o + 4'd1;
                    end
                    if (last_centre) state <= ctrl_pkg::st_drain;
                end
                ctrl_pkg::st_drain: begin
                    drain_cnt <= drain_cnt + 3'd1;
                    if (drain_end) begin
                        drain_cnt <= '0;
                        read_start_o <= 1'b1;  // first cycle of st_read
                        state <= ctrl_pkg::st_read;
                    end
                end
                ctrl_pkg::st_read: begin
                    if (last_i) begin
                        frame_done_o <= 1'b1;
                        state <= ctrl_pkg::st_load;
                    end
                end
                default: state <= ctrl_pkg::st_load;
            endcase
        end
    end

    always_ff @(posedge clk_100mhz) begin
        addr_pipe[0] <= blur_pkg::pix_addr_t'(row_o * blur_pkg::frame_dim + col_o);
        for (int i = 1; i < 4; i++) begin
            addr_pipe[i] <= addr_pipe[i - 1];
        end
        res_wr_o.addr <= addr_pipe[3];
        res_wr_o.data <= filt_pix_i;
    end

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) res_wr_o.valid <= 1'b0;
        else res_wr_o.valid <= filt_valid_i;
    end

    a_write_in_blur : assert property (
        @(posedge clk_100mhz) disable iff (sys_rst)
        res_wr_o.valid |-> state inside {ctrl_pkg::st_blur, ctrl_pkg::st_drain}
    ) else $error("result write outside blur/drain");

endmodule

// File: src/blur_pkg.sv
package blur_pkg;

    // frame geometry
    localparam int frame_dim = 16;
    localparam int frame_pixels = frame_dim * frame_dim;

    // gaussian normalisation: (sum + 8) >> 4
    localparam int round_const = 8;
    localparam int norm_shift = 4;

    typedef logic [7:0] pixel_t;     // greyscale value
    typedef logic [7:0] pix_addr_t;  // row * frame_dim + col
    typedef logic [3:0] coord_t;     // row or column index

    localparam coord_t coord_last = coord_t'(frame_dim - 1);
    localparam pix_addr_t addr_last = pix_addr_t'(frame_pixels - 1);

    // one row of the 3x3 window, left pixel in the top bits
    typedef struct packed {
        pixel_t l;
        pixel_t c;
        pixel_t r;
    } win_row_t;

    // full window, top-left pixel first
    typedef struct packed {
        win_row_t top;
        win_row_t mid;
        win_row_t bot;
    } window_t;

    // write port request, shared by both frame buffers
    typedef struct packed {
        logic      valid;
        pix_addr_t addr;
        pixel_t    data;
    } write_req_t;

endpackage

// File: src/blur_top.sv
module blur_top (
    input  logic              clk_100mhz,
    input  logic              sys_rst,
    input  blur_pkg::pixel_t  in_pixel_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    output blur_pkg::pixel_t  out_pixel_o,
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output ctrl_pkg::status_t status_o,
    output logic              frame_done_o
);

    logic load_en;
    logic full;
    logic last;
    logic issue;
    logic read_start;
    blur_pkg::coord_t row;
    blur_pkg::coord_t col;
    ctrl_pkg::tap_t tap;

    blur_pkg::write_req_t src_wr;   // loader into source buffer
    blur_pkg::write_req_t res_wr;   // filter results into result buffer
    blur_pkg::pix_addr_t src_rd_addr;
    blur_pkg::pix_addr_t res_rd_addr;
    blur_pkg::pixel_t src_rd_data;
    blur_pkg::pixel_t res_rd_data;

    blur_pkg::window_t win;
    logic win_valid;
    blur_pkg::pixel_t filt_pix;
    logic filt_valid;

    blur_controller ctrl0 (
        .clk_100mhz   (clk_100mhz),
        .sys_rst      (sys_rst),
        .full_i       (full),
        .last_i       (last),
        .load_en_o    (load_en),
        .issue_o      (issue),
        .row_o        (row),
        .col_o        (col),
        .tap_o        (tap),
        .filt_valid_i (filt_valid),
        .filt_pix_i   (filt_pix),
        .res_wr_o     (res_wr),
        .read_start_o (read_start),
        .status_o     (status_o),
        .frame_done_o (frame_done_o)
    );

    image_loader loader0 (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .load_en_i  (load_en),
        .in_pixel_i (in_pixel_i),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .wr_o       (src_wr),
        .full_o     (full)
    );

    pixel_ram src_ram (
        .clk_100mhz (clk_100mhz),
        .wr_i       (src_wr),
        .rd_addr_i  (src_rd_addr),
        .rd_data_o  (src_rd_data)
    );

    window_fetch fetch0 (
        .clk_100mhz  (clk_100mhz),
        .sys_rst     (sys_rst),
        .issue_i     (issue),
        .row_i       (row),
        .col_i       (col),
        .tap_i       (tap),
        .rd_addr_o   (src_rd_addr),
        .rd_data_i   (src_rd_data),
        .win_o       (win),
        .win_valid_o (win_valid)
    );

    gaussian_3x3 filt0 (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .win_i      (win),
        .valid_i    (win_valid),
        .pix_o      (filt_pix),
        .valid_o    (filt_valid)
    );

    pixel_ram res_ram (
        .clk_100mhz (clk_100mhz),
        .wr_i       (res_wr),
        .rd_addr_i  (res_rd_addr),
        .rd_data_o  (res_rd_data)
    );

    result_streamer stream0 (
        .clk_100mhz  (clk_100mhz),
        .sys_rst     (sys_rst),
        .start_i     (read_start),
        .rd_addr_o   (res_rd_addr),
        .rd_data_i   (res_rd_data),
        .out_pixel_o (out_pixel_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .last_o      (last)
    );

endmodule

// File: src/ctrl_pkg.sv
package ctrl_pkg;

    typedef enum logic [2:0] {
        st_load,   // filling the source buffer
        st_blur,   // issuing taps for every centre
        st_drain,  // waiting for the filter pipe to empty
        st_read    // streaming the result buffer out
    } ctrl_state_e;

    // kernel tap, raster order inside the window
    typedef logic [3:0] tap_t;

    localparam tap_t tap_last = tap_t'(8);

    // tap 8 issue to result write
    localparam int drain_cycles = 5;

    typedef struct packed {
        logic loading;
        logic blurring;
        logic reading;
    } status_t;

endpackage

// File: src/gaussian_3x3.sv
module gaussian_3x3 (
    input  logic              clk_100mhz,
    input  logic              sys_rst,
    input  blur_pkg::window_t win_i,
    input  logic              valid_i,
    output blur_pkg::pixel_t  pix_o,
    output logic              valid_o
);

    logic [9:0] sum_top;   // l + 2c + r
    logic [10:0] sum_mid;  // twice the centre row
    logic [9:0] sum_bot;
    logic [11:0] total;
    logic valid_s1;

    // 1 2 1 weighting of one row
    function automatic logic [9:0] row_sum(input blur_pkg::win_row_t row);
        logic [9:0] acc;
        acc = 10'(row.l) + {1'b0, row.c, 1'b0} + 10'(row.r);
        return acc;
    endfunction

    // stage one: weighted row sums
    always_ff @(posedge clk_100mhz) begin
        sum_top <= row_sum(win_i.top);
        sum_mid <= {row_sum(win_i.mid), 1'b0};
        sum_bot <= row_sum(win_i.bot);
    end

    // max 4080 + 8, fits in 12 bits
    assign total = 12'(sum_top) + 12'(sum_mid) + 12'(sum_bot)
                   + 12'(blur_pkg::round_const);

    // stage two: round and normalise by 16
    always_ff @(posedge clk_100mhz) begin
        pix_o <= blur_pkg::pixel_t'(total >> blur_pkg::norm_shift);
    end

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            valid_s1 <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            valid_s1 <= valid_i;
            valid_o <= valid_s1;
        end
    end

endmodule

// File: src/image_loader.sv
module image_loader (
    input  logic                 clk_100mhz,
    input  logic                 sys_rst,
    input  logic                 load_en_i,
    input  blur_pkg::pixel_t     in_pixel_i,
    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    output blur_pkg::write_req_t wr_o,
    output logic                 full_o
);

    blur_pkg::pix_addr_t wr_addr;
    logic accept;

    // the controller leaves st_load on the edge that takes the last pixel
    assign in_ready_o = load_en_i;
    assign accept = in_valid_i && in_ready_o;

    assign wr_o.valid = accept;
    assign wr_o.addr = wr_addr;
    assign wr_o.data = in_pixel_i;

    assign full_o = accept && (wr_addr == blur_pkg::addr_last);

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            wr_addr <= '0;
        end else begin
            if (accept) begin
                wr_addr <= wr_addr + 8'd1;  // wraps to 0 after the last pixel
            end
        end
    end

    a_no_write_after_full : assert property (
        @(posedge clk_100mhz) disable iff (sys_rst) full_o |=> !wr_o.valid
    ) else $error("source write after the last pixel of the frame");

endmodule

// File: src/pixel_ram.sv
module pixel_ram (
    input  logic                 clk_100mhz,
    input  blur_pkg::write_req_t wr_i,
    input  blur_pkg::pix_addr_t  rd_addr_i,
    output blur_pkg::pixel_t     rd_data_o
);

    blur_pkg::pixel_t mem [blur_pkg::frame_pixels];

    always_ff @(posedge clk_100mhz) begin
        if (wr_i.valid) begin
            mem[wr_i.addr] <= wr_i.data;
        end
    end

    // registered read, old data wins on a same-address write
    always_ff @(posedge clk_100mhz) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

// File: src/result_streamer.sv
module result_streamer (
    input  logic                clk_100mhz,
    input  logic                sys_rst,
    input  logic                start_i,
    output blur_pkg::pix_addr_t rd_addr_o,
    input  blur_pkg::pixel_t    rd_data_i,
    output blur_pkg::pixel_t    out_pixel_o,
    output logic                out_valid_o,
    input  logic                out_ready_i,
    output logic                last_o
);

    blur_pkg::pix_addr_t cnt;  // index of the pixel on rd_data_i
    logic avail;               // rd_data_i holds pixel cnt
    logic out_last;
    logic load;

    // take the ram output when the output register frees up
    assign load = avail && (!out_valid_o || out_ready_i);

    // address is held while stalled so rd_data_i keeps its pixel
    assign rd_addr_o = load ? cnt + 8'd1 : cnt;

    assign last_o = out_valid_o && out_ready_i && out_last;

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            cnt <= '0;
            avail <= 1'b0;
            out_valid_o <= 1'b0;
            out_last <= 1'b0;
        end else begin
            if (start_i) begin
                cnt <= '0;
                avail <= 1'b1;
            end else if (load) begin
                cnt <= cnt + 8'd1;
                if (cnt == blur_pkg::addr_last) avail <= 1'b0;
            end
            if (load) begin
                out_valid_o <= 1'b1;
                out_last <= (cnt == blur_pkg::addr_last);
            end else if (out_ready_i) begin
                out_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (load) out_pixel_o <= rd_data_i;
    end

    a_start_when_idle : assert property (
        @(posedge clk_100mhz) disable iff (sys_rst)
        start_i |-> !avail && !out_valid_o
    ) else $error("read start while a frame is still streaming");

endmodule

// File: src/window_fetch.sv
module window_fetch (
    input  logic                clk_100mhz,
    input  logic                sys_rst,
    input  logic                issue_i,
    input  blur_pkg::coord_t    row_i,
    input  blur_pkg::coord_t    col_i,
    input  ctrl_pkg::tap_t      tap_i,
    output blur_pkg::pix_addr_t rd_addr_o,
    input  blur_pkg::pixel_t    rd_data_i,
    output blur_pkg::window_t   win_o,
    output logic                win_valid_o
);

    blur_pkg::coord_t nb_row;
    blur_pkg::coord_t nb_col;
    ctrl_pkg::tap_t tap_d1;  // tap whose pixel is on rd_data_i
    logic valid_d1;

    // neighbour coordinate, clamped at the frame edges
    always_comb begin
        nb_row = row_i;
        nb_col = col_i;
        if (tap_i < 4'd3) begin
            if (row_i != 4'd0) nb_row = row_i - 4'd1;
        end else if (tap_i > 4'd5) begin
            if (row_i != blur_pkg::coord_last) nb_row = row_i + 4'd1;
        end
        case (tap_i)
            4'd0, 4'd3, 4'd6: begin
                if (col_i != 4'd0) nb_col = col_i - 4'd1;
            end
            4'd2, 4'd5, 4'd8: begin
                if (col_i != blur_pkg::coord_last) nb_col = col_i + 4'd1;
            end
            default: ;  // centre column
        endcase
    end

    assign rd_addr_o = blur_pkg::pix_addr_t'(nb_row * blur_pkg::frame_dim + nb_col);

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            valid_d1 <= 1'b0;
            win_valid_o <= 1'b0;
        end else begin
            valid_d1 <= issue_i;
            win_valid_o <= valid_d1 && (tap_d1 == ctrl_pkg::tap_last);
        end
    end

    always_ff @(posedge clk_100mhz) begin
        tap_d1 <= tap_i;
    end

    // place the returning pixel into its window slot
    always_ff @(posedge clk_100mhz) begin
        if (valid_d1) begin
            case (tap_d1)
                4'd0: win_o.top.l <= rd_data_i;
                4'd1: win_o.top.c <= rd_data_i;
                4'd2: win_o.top.r <= rd_data_i;
                4'd3: win_o.mid.l <= rd_data_i;
                4'd4: win_o.mid.c <= rd_data_i;
                4'd5: win_o.mid.r <= rd_data_i;
                4'd6: win_o.bot.l <= rd_data_i;
                4'd7: win_o.bot.c <= rd_data_i;
                default: win_o.bot.r <= rd_data_i;
            endcase
        end
    end

    a_tap_in_range : assert property (
        @(posedge clk_100mhz) disable iff (sys_rst) issue_i |-> tap_i <= ctrl_pkg::tap_last
    ) else $error("tap index out of range: %0d", tap_i);

endmodule

// File: verification/blur_tb.sv
module blur_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int load_timeout = 2000;
    localparam int read_timeout = 20000;   // blur is about 2300 cycles plus readout
    localparam int impulse_addr = 7 * 16 + 4;

    typedef enum {pat_const, pat_hramp, pat_impulse, pat_random} pattern_e;

    typedef struct {
        string    name;
        pattern_e kind;
        int       value;
        bit       rand_ready;  // random back-pressure on the output stream
    } frame_case_t;

    logic clk_100mhz = 1'b0;
    logic sys_rst = 1'b1;
    blur_pkg::pixel_t in_pixel_i = '0;
    logic in_valid_i = 1'b0;
    logic in_ready_o;
    blur_pkg::pixel_t out_pixel_o;
    logic out_valid_o;
    logic out_ready_i = 1'b0;
    ctrl_pkg::status_t status_o;
    logic frame_done_o;

    frame_case_t cases [$];
    blur_pkg::pixel_t src_pix [blur_pkg::frame_pixels];
    logic [31:0] rng_state = 32'd6639;
    int check_cnt = 0;
    int value_errs = 0;
    int other_errs = 0;

    blur_top dut0 (
        .clk_100mhz   (clk_100mhz),
        .sys_rst      (sys_rst),
        .in_pixel_i   (in_pixel_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .out_pixel_o  (out_pixel_o),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .status_o     (status_o),
        .frame_done_o (frame_done_o)
    );

    always #5 clk_100mhz = ~clk_100mhz;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic bit rand_bit();
        rng_state = xorshift32(rng_state);
        return rng_state[7];
    endfunction

    function automatic ctrl_pkg::status_t status_of(input bit l, input bit b, input bit r);
        ctrl_pkg::status_t s;
        s.loading = l;
        s.blurring = b;
        s.reading = r;
        return s;
    endfunction

    task automatic add_case(input string name, input pattern_e kind, input int value,
                            input bit rand_ready);
        frame_case_t c;
        c.name = name;
        c.kind = kind;
        c.value = value;
        c.rand_ready = rand_ready;
        cases.push_back(c);
    endtask

    function automatic void fill_source(input frame_case_t fc);
        for (int p = 0; p < blur_pkg::frame_pixels; p++) begin
            case (fc.kind)
                pat_const: src_pix[p] = blur_pkg::pixel_t'(fc.value);
                pat_hramp: src_pix[p] = blur_pkg::pixel_t'((p % 16) * fc.value);
                pat_impulse: src_pix[p] = (p == impulse_addr) ? blur_pkg::pixel_t'(fc.value) : '0;
                default: begin
                    rng_state = xorshift32(rng_state);
                    src_pix[p] = rng_state[15:8];
                end
            endcase
        end
    endfunction

    function automatic int clamp_coord(input int v);
        if (v < 0) return 0;
        if (v > 15) return 15;
        return v;
    endfunction

    // weights 1 2 1 / 2 4 2 / 1 2 1, edges repeat the border pixel
    function automatic blur_pkg::pixel_t blur_ref(input int row, input int col);
        int sum;
        int w;
        sum = 8;  // rounding before the divide by 16
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                w = ((dr == 0) ? 2 : 1) * ((dc == 0) ? 2 : 1);
                sum += w * int'(src_pix[clamp_coord(row + dr) * 16 + clamp_coord(col + dc)]);
            end
        end
        return blur_pkg::pixel_t'(sum / 16);
    endfunction

    task automatic check_pixel(input string name, input blur_pkg::pixel_t exp_v,
                               input blur_pkg::pixel_t act_v);
        check_cnt++;
        if (act_v !== exp_v) begin
            value_errs++;
            $display("error: %s expected %0d actual %0d", name, exp_v, act_v);
        end
    endtask

    task automatic check_status(input string name, input ctrl_pkg::status_t exp_v,
                                input ctrl_pkg::status_t act_v);
        check_cnt++;
        if (act_v !== exp_v) begin
            value_errs++;
            $display("error: %s expected %b actual %b", name, exp_v, act_v);
        end
    endtask

    task automatic verify_flag(input string name, input logic exp_v, input logic act_v);
        check_cnt++;
        if (act_v !== exp_v) begin
            value_errs++;
            $display("error: %s expected %b actual %b", name, exp_v, act_v);
        end
    endtask

    // load one frame, wait for the blur and collect the output stream
    task automatic run_frame(input frame_case_t fc, output bit ok);
        blur_pkg::pixel_t exp_pix [blur_pkg::frame_pixels];
        int idx;
        int cycles;
        int out_cnt;
        int done_cnt;
        bit seen_valid;
        bit stalled;
        ok = 1'b0;
        fill_source(fc);
        for (int p = 0; p < blur_pkg::frame_pixels; p++) exp_pix[p] = blur_ref(p / 16, p % 16);

        idx = 0;
        cycles = 0;
        in_pixel_i <= src_pix[0];
        in_valid_i <= 1'b1;
        out_ready_i <= fc.rand_ready ? rand_bit() : 1'b1;
        while (idx < blur_pkg::frame_pixels && cycles < load_timeout) begin
            @(posedge clk_100mhz);
            cycles++;
            if (in_valid_i && in_ready_o) begin
                idx++;
                if (idx < blur_pkg::frame_pixels) in_pixel_i <= src_pix[idx];
                else in_valid_i <= 1'b0;
            end
        end
        if (idx < blur_pkg::frame_pixels) begin
            $display("timeout: %s accepted only %0d input pixels", fc.name, idx);
            other_errs++;
            return;
        end

        @(posedge clk_100mhz);  // controller has left st_load
        check_status($sformatf("%s blur status", fc.name), status_of(1'b0, 1'b1, 1'b0),
                     status_o);

        out_cnt = 0;
        done_cnt = 0;
        seen_valid = 1'b0;
        stalled = 1'b0;
        cycles = 0;
        while (done_cnt == 0 && cycles < read_timeout) begin
            @(posedge clk_100mhz);
            cycles++;
            if (status_o.blurring || status_o.reading) begin
                verify_flag($sformatf("%s in_ready while busy", fc.name), 1'b0, in_ready_o);
            end
            if (stalled && !out_valid_o) begin
                $display("%s: out_valid_o dropped before pixel %0d was taken", fc.name, out_cnt);
                other_errs++;
            end
            if (out_valid_o && !seen_valid) begin
                seen_valid = 1'b1;
                check_status($sformatf("%s read status", fc.name), status_of(1'b0, 1'b0, 1'b1),
                             status_o);
            end
            // the offered pixel must be the next one in raster order, stalled or not
            if (out_valid_o) begin
                if (out_cnt < blur_pkg::frame_pixels) begin
                    check_pixel($sformatf("%s pixel %0d", fc.name, out_cnt), exp_pix[out_cnt],
                                out_pixel_o);
                end else if (out_ready_i) begin
                    $display("%s: extra pixel transferred after the full frame", fc.name);
                    other_errs++;
                end
                if (out_ready_i) out_cnt++;
            end
            stalled = out_valid_o && !out_ready_i;
            if (frame_done_o) done_cnt++;
            out_ready_i <= fc.rand_ready ? rand_bit() : 1'b1;
        end
        if (done_cnt == 0) begin
            $display("timeout: %s frame_done_o never pulsed, %0d pixels received",
                     fc.name, out_cnt);
            other_errs++;
            return;
        end
        if (out_cnt != blur_pkg::frame_pixels) begin
            $display("%s: frame_done_o came after %0d transfers instead of %0d",
                     fc.name, out_cnt, blur_pkg::frame_pixels);
            other_errs++;
        end

        // one pulse only, then back to loading
        for (int k = 0; k < 4; k++) begin
            @(posedge clk_100mhz);
            if (k == 0) begin
                check_status($sformatf("%s idle status", fc.name),
                             status_of(1'b1, 1'b0, 1'b0), status_o);
                verify_flag($sformatf("%s in_ready after frame", fc.name), 1'b1, in_ready_o);
            end
            if (frame_done_o) begin
                $display("%s: frame_done_o pulsed more than once", fc.name);
                other_errs++;
            end
            if (out_valid_o) begin
                $display("%s: output valid after the frame was complete", fc.name);
                other_errs++;
            end
        end
        ok = 1'b1;
    endtask

    initial begin
        bit ok;
        ok = 1'b1;
        add_case("const_77", pat_const, 77, 1'b0);
        add_case("ramp_h", pat_hramp, 13, 1'b0);
        add_case("impulse", pat_impulse, 160, 1'b0);
        add_case("random_a", pat_random, 0, 1'b0);
        add_case("random_bp", pat_random, 0, 1'b1);
        add_case("const_255_bp", pat_const, 255, 1'b1);   // largest sum in the filter

        repeat (3) @(posedge clk_100mhz);
        sys_rst <= 1'b0;
        @(posedge clk_100mhz);
        check_status("reset status", status_of(1'b1, 1'b0, 1'b0), status_o);
        verify_flag("reset in_ready", 1'b1, in_ready_o);
        verify_flag("reset out_valid", 1'b0, out_valid_o);

        // frames run back to back without a reset in between
        for (int i = 0; i < cases.size() && ok; i++) begin
            run_frame(cases[i], ok);
        end

        $display("checks %0d, value errors %0d, other failures %0d",
                 check_cnt, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
